// ==== compile.f ====
+incdir+include
design/io_pkg.sv
design/reg_bus_if.sv
design/io_router.sv
design/clint.sv
design/plic.sv
design/io_subsys_top.sv
verification/io_subsys_checker.sv
verification/io_subsys_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= io_subsys_tb
LOG ?= sim.log
OBJ_DIR ?= obj_dir
RUN_ARGS ?= +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) -Mdir $(OBJ_DIR) -f compile.f
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	grep -q "TEST PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verification/io_subsys_tb.sv ====
`timescale 1ns/1ps
`include "io_defines.svh"

module io_subsys_tb;
  import io_pkg::*;

  // timer wait ~200, random traffic ~80 transfers of up to ~12 cycles
  localparam int TIMEOUT_CYCLES = 5000;
  localparam io_addr_t UART_BASE = 32'h1000_0000;
  localparam io_addr_t SD_BASE = 32'h1001_0000;

  logic      clk_i;
  logic      reset_i;
  logic      req_valid_i;
  logic      req_write_i;
  io_addr_t  req_addr_i;
  io_data_t  req_wdata_i;
  logic      rsp_ready_i;
  logic      irq_uart_i;
  logic      irq_sd_i;
  logic      req_ready_o;
  logic      rsp_valid_o;
  io_data_t  rsp_rdata_o;
  logic      rsp_error_o;
  hart_vec_t msip_o;
  hart_vec_t mtip_o;
  hart_vec_t meip_o;

  int unsigned error_count = 0;
  int unsigned cycle_count = 0;
  logic [31:0] lcg_state = 32'd35;

  io_subsys_top io_subsys_top_inst (.*);

  initial clk_i = 1'b0;
  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // writable bits per register
  function automatic io_data_t expected_readback(input io_addr_t addr, input io_data_t wdata);
    io_data_t mask;
    mask = '0;
    for (int h = 0; h < `NUM_HARTS; h++) begin
      if (addr == `CLINT_BASE + `CLINT_MSIP_OFS + 32'(4 * h))
        mask = 64'h1;
      if (addr == `CLINT_BASE + `CLINT_MTIMECMP_OFS + 32'(8 * h))
        mask = '1;
      if (addr == `PLIC_BASE + `PLIC_ENABLE_OFS + 32'(128 * h))
        mask = 64'hFFFF_FFFE;
    end
    return wdata & mask;
  endfunction

  function automatic irq_id_t expected_claim(input irq_vec_t pend, input irq_vec_t en);
    irq_vec_t both;
    both = pend & en;
    for (int i = 1; i < `NUM_IRQS; i++) begin
      if (both[i])
        return irq_id_t'(i);
    end
    return '0;
  endfunction

  task automatic check_equal(input io_data_t actual, input io_data_t expected,
                             input string msg);
    if (actual !== expected) begin
      $display("FAIL %0t: %s, got %h expected %h", $time, msg, actual, expected);
      error_count++;
    end
  endtask

  task automatic next_cycle(input int n);
    repeat (n) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  // handshakes sampled mid-cycle, completed on the next rising edge
  task automatic bus_transfer(input logic write, input io_addr_t addr, input io_data_t wdata,
                              input int stall, output io_data_t rdata, output logic err);
    logic done;
    done        = 1'b0;
    req_valid_i = 1'b1;
    req_write_i = write;
    req_addr_i  = addr;
    req_wdata_i = wdata;
    rsp_ready_i = (stall == 0);
    while (!done) begin
      @(negedge clk_i);
      done = req_ready_o;
      next_cycle(1);
    end
    req_valid_i = 1'b0;
    next_cycle(stall);
    rsp_ready_i = 1'b1;
    done = 1'b0;
    while (!done) begin
      @(negedge clk_i);
      done  = rsp_valid_o;
      rdata = rsp_rdata_o;
      err   = rsp_error_o;
      next_cycle(1);
    end
  endtask

  task automatic bus_write(input io_addr_t addr, input io_data_t wdata, input int stall,
                           output logic err);
    io_data_t unused;
    bus_transfer(1'b1, addr, wdata, stall, unused, err);
  endtask

  task automatic bus_read(input io_addr_t addr, input int stall, output io_data_t rdata,
                          output logic err);
    bus_transfer(1'b0, addr, '0, stall, rdata, err);
  endtask

  initial begin
    io_data_t  rdata;
    io_data_t  wdata;
    io_data_t  t_start;
    io_addr_t  addr;
    logic      err;
    irq_vec_t  model_pending;
    irq_vec_t  enable0;
    irq_id_t   exp_id;
    int        n;
    int        idx;
    int        stall;
    int unsigned assert_fails;

    reset_i     = 1'b1;
    req_valid_i = 1'b0;
    req_write_i = 1'b0;
    req_addr_i  = '0;
    req_wdata_i = '0;
    rsp_ready_i = 1'b1;
    irq_uart_i  = 1'b0;
    irq_sd_i    = 1'b0;
    repeat (2) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    check_equal(io_data_t'(req_ready_o), 64'd1, "req_ready after reset");

    ////////////////////////////////////////////////////////////
    // software interrupts
    addr = `CLINT_BASE + `CLINT_MSIP_OFS + 32'd4;
    bus_write(addr, 64'd1, 0, err);
    bus_read(addr, 0, rdata, err);
    check_equal(rdata, expected_readback(addr, 64'd1), "msip1 read-back");
    next_cycle(2);
    check_equal(io_data_t'(msip_o), 64'd2, "msip_o set");
    bus_write(addr, 64'd0, 0, err);
    next_cycle(2);
    check_equal(io_data_t'(msip_o), 64'd0, "msip_o cleared");

    ////////////////////////////////////////////////////////////
    // timer
    bus_read(`CLINT_BASE + `CLINT_MTIME_OFS, 0, t_start, err);
    check_equal(io_data_t'(mtip_o[0]), 64'd0, "mtip0 before mtimecmp write");
    bus_write(`CLINT_BASE + `CLINT_MTIMECMP_OFS, t_start + 64'd200, 0, err);
    n = 0;
    while (!mtip_o[0] && n < 400) begin
      next_cycle(1);
      n++;
    end
    check_equal(io_data_t'(mtip_o[0]), 64'd1, "mtip0 rises");
    bus_read(`CLINT_BASE + `CLINT_MTIME_OFS, 0, rdata, err);
    check_equal(io_data_t'(rdata >= t_start + 64'd200), 64'd1, "mtime past mtimecmp");
    check_equal(io_data_t'(mtip_o[1]), 64'd0, "mtip1 stays low");

    ////////////////////////////////////////////////////////////
    // claim and complete
    wdata = 64'h6;
    bus_write(`PLIC_BASE + `PLIC_ENABLE_OFS, wdata, 0, err);
    enable0 = irq_vec_t'(expected_readback(`PLIC_BASE + `PLIC_ENABLE_OFS, wdata));
    irq_uart_i = 1'b1;
    irq_sd_i   = 1'b1;
    n = 0;
    while (!meip_o[0] && n < 20) begin
      next_cycle(1);
      n++;
    end
    check_equal(io_data_t'(meip_o[0]), 64'd1, "meip0 rises");
    check_equal(io_data_t'(meip_o[1]), 64'd0, "meip1 stays low");
    model_pending = '0;
    model_pending[`IRQ_UART] = 1'b1;
    model_pending[`IRQ_SD]   = 1'b1;
    repeat (3) begin
      bus_read(`PLIC_BASE + `PLIC_CLAIM_OFS, 0, rdata, err);
      exp_id = expected_claim(model_pending, enable0);
      check_equal(rdata, io_data_t'(exp_id), "claim id");
      if (exp_id != '0)
        model_pending[exp_id] = 1'b0;
    end
    next_cycle(2);
    check_equal(io_data_t'(meip_o[0]), 64'd0, "meip0 falls after claims");
    bus_write(`PLIC_BASE + `PLIC_CLAIM_OFS, 64'(`IRQ_UART), 0, err);
    n = 0;
    while (!meip_o[0] && n < 20) begin
      next_cycle(1);
      n++;
    end
    check_equal(io_data_t'(meip_o[0]), 64'd1, "meip0 rises after complete");
    irq_uart_i = 1'b0;
    irq_sd_i   = 1'b0;
    bus_write(`PLIC_BASE + `PLIC_CLAIM_OFS, 64'(`IRQ_SD), 0, err);

    ////////////////////////////////////////////////////////////
    // unmapped windows
    for (int k = 0; k < 2; k++) begin
      addr = (k == 0) ? UART_BASE : SD_BASE;
      bus_write(addr, 64'hDEAD_BEEF, 0, err);
      check_equal(io_data_t'(err), 64'd1, "unmapped write error");
      bus_read(addr, 0, rdata, err);
      check_equal(io_data_t'(err), 64'd1, "unmapped read error");
      check_equal(rdata, 64'd0, "unmapped read data");
    end
    bus_read(`PLIC_BASE + `PLIC_PENDING_OFS, 0, rdata, err);
    check_equal(io_data_t'(err), 64'd0, "mapped read error");

    ////////////////////////////////////////////////////////////
    // random register traffic
    for (int i = 0; i < 40; i++) begin
      lcg_state = lcg_next(lcg_state);
      idx = int'(lcg_state[20]);
      stall = (lcg_state[19:18] == 2'd0) ? 3 + int'(lcg_state[17:16]) : 0;
      case (int'(lcg_state[31:24]) % 3)
        0:       addr = `CLINT_BASE + `CLINT_MSIP_OFS + 32'(4 * idx);
        1:       addr = `CLINT_BASE + `CLINT_MTIMECMP_OFS + 32'(8 * idx);
        default: addr = `PLIC_BASE + `PLIC_ENABLE_OFS + 32'(128 * idx);
      endcase
      wdata[63:32] = lcg_state;
      lcg_state = lcg_next(lcg_state);
      wdata[31:0] = lcg_state;
      bus_write(addr, wdata, stall, err);
      check_equal(io_data_t'(err), 64'd0, "random write error");
      bus_read(addr, stall, rdata, err);
      check_equal(rdata, expected_readback(addr, wdata), "random read-back");
    end

    assert_fails = io_subsys_top_inst.io_subsys_checker_inst.hold_fails
                 + io_subsys_top_inst.io_subsys_checker_inst.ready_fails
                 + io_subsys_top_inst.io_subsys_checker_inst.reset_fails;
    $display("errors: %0d check, %0d assertion", error_count, assert_fails);
    if (error_count == 0 && assert_fails == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== verification/io_subsys_checker.sv ====
`timescale 1ns/1ps

module io_subsys_checker (
  input logic              clk_i,
  input logic              reset_i,
  input logic              req_ready_i,
  input logic              rsp_valid_i,
  input logic              rsp_ready_i,
  input io_pkg::io_data_t  rsp_rdata_i,
  input logic              rsp_error_i,
  input io_pkg::hart_vec_t msip_i,
  input io_pkg::hart_vec_t mtip_i,
  input io_pkg::hart_vec_t meip_i
);

  int unsigned hold_fails = 0;
  int unsigned ready_fails = 0;
  int unsigned reset_fails = 0;

  // response stays put while stalled
  rsp_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    rsp_valid_i && !rsp_ready_i |=>
      rsp_valid_i && $stable(rsp_rdata_i) && $stable(rsp_error_i))
    else begin
      $error("response changed while rsp_ready was low");
      hold_fails++;
    end

  // single outstanding request
  ready_low: assert property (@(posedge clk_i) disable iff (reset_i)
    rsp_valid_i |-> !req_ready_i)
    else begin
      $error("req_ready high while a response is pending");
      ready_fails++;
    end

  reset_state: assert property (@(posedge clk_i)
    reset_i |=> !rsp_valid_i && msip_i == '0 && mtip_i == '0 && meip_i == '0)
    else begin
      $error("outputs not cleared after reset");
      reset_fails++;
    end

endmodule

bind io_subsys_top io_subsys_checker io_subsys_checker_inst (
  .clk_i       (clk_i),
  .reset_i     (reset_i),
  .req_ready_i (req_ready_o),
  .rsp_valid_i (rsp_valid_o),
  .rsp_ready_i (rsp_ready_i),
  .rsp_rdata_i (rsp_rdata_o),
  .rsp_error_i (rsp_error_o),
  .msip_i      (msip_o),
  .mtip_i      (mtip_o),
  .meip_i      (meip_o)
);

// ==== design/io_subsys_top.sv ====
`timescale 1ns/1ps
`include "io_defines.svh"

module io_subsys_top (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              req_valid_i,
  input  logic              req_write_i,
  input  io_pkg::io_addr_t  req_addr_i,
  input  io_pkg::io_data_t  req_wdata_i,
  input  logic              rsp_ready_i,
  input  logic              irq_uart_i,
  input  logic              irq_sd_i,
  output logic              req_ready_o,
  output logic              rsp_valid_o,
  output io_pkg::io_data_t  rsp_rdata_o,
  output logic              rsp_error_o,
  output io_pkg::hart_vec_t msip_o,
  output io_pkg::hart_vec_t mtip_o,
  output io_pkg::hart_vec_t meip_o
);
  import io_pkg::*;

  irq_vec_t irq_sources;

  reg_bus_if host_bus ();
  reg_bus_if clint_bus ();
  reg_bus_if plic_bus ();

  // host side driven from the pins
  assign host_bus.req_valid = req_valid_i;
  assign host_bus.req_write = req_write_i;
  assign host_bus.req_addr  = req_addr_i;
  assign host_bus.req_wdata = req_wdata_i;
  assign host_bus.rsp_ready = rsp_ready_i;

  assign req_ready_o = host_bus.req_ready;
  assign rsp_valid_o = host_bus.rsp_valid;
  assign rsp_rdata_o = host_bus.rsp_rdata;
  assign rsp_error_o = host_bus.rsp_error;

  io_router io_router_inst (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .up_bus    (host_bus),
    .clint_bus (clint_bus),
    .plic_bus  (plic_bus)
  );

  clint clint_inst (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .bus     (clint_bus),
    .msip_o  (msip_o),
    .mtip_o  (mtip_o)
  );

  ////////////////////////////////////////////////////////////
  // irq routing, both lines level-triggered

  always_comb begin
    irq_sources            = '0;
    irq_sources[`IRQ_UART] = irq_uart_i;
    irq_sources[`IRQ_SD]   = irq_sd_i;
  end

  plic plic_inst (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .bus           (plic_bus),
    .irq_sources_i (irq_sources),
    .meip_o        (meip_o)
  );

endmodule

// ==== design/plic.sv ====
`timescale 1ns/1ps
`include "io_defines.svh"

module plic (
  input  logic              clk_i,
  input  logic              reset_i,
  reg_bus_if.device         bus,
  input  io_pkg::irq_vec_t  irq_sources_i,
  output io_pkg::hart_vec_t meip_o
);
  import io_pkg::*;

  irq_vec_t  pending_q;
  irq_vec_t  in_service_q;
  irq_vec_t  enable_q [`NUM_HARTS];
  irq_id_t   claim_id [`NUM_HARTS];
  hart_vec_t enable_sel;
  hart_vec_t claim_sel;
  irq_vec_t  gw_set;
  irq_vec_t  claim_clr;
  irq_vec_t  complete_clr;
  io_addr_t  ofs;
  io_data_t  rd_data;
  io_data_t  rdata_q;
  logic      rsp_valid_q;
  logic      accept;
  logic      rsp_done;

  // lowest set bit wins, source 0 excluded
  function automatic irq_id_t lowest_id(input irq_vec_t v);
    irq_id_t id;
    id = '0;
    for (int i = `NUM_IRQS - 1; i > 0; i--) begin
      if (v[i])
        id = irq_id_t'(i);
    end
    return id;
  endfunction

  assign ofs      = bus.req_addr & `PLIC_MASK;
  assign accept   = bus.req_valid & bus.req_ready;
  assign rsp_done = bus.rsp_valid & bus.rsp_ready;

  assign bus.req_ready = ~rsp_valid_q;
  assign bus.rsp_valid = rsp_valid_q;
  assign bus.rsp_rdata = rdata_q;
  assign bus.rsp_error = 1'b0;

  ////////////////////////////////////////////////////////////
  // register decode

  always_comb begin
    rd_data    = '0;
    enable_sel = '0;
    claim_sel  = '0;
    if (ofs == `PLIC_PENDING_OFS)
      rd_data = io_data_t'(pending_q);
    for (int c = 0; c < `NUM_HARTS; c++) begin
      claim_id[c] = lowest_id(pending_q & enable_q[c]);
      if (ofs == `PLIC_ENABLE_OFS + io_addr_t'(32'h80 * c)) begin
        enable_sel[c] = 1'b1;
        rd_data       = io_data_t'(enable_q[c]);
      end
      if (ofs == `PLIC_CLAIM_OFS + io_addr_t'(32'h1000 * c)) begin
        claim_sel[c] = 1'b1;
        rd_data      = io_data_t'(claim_id[c]);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // gateway and claim/complete

  // level gateway, blocked while pending or in service
  assign gw_set = irq_sources_i & ~pending_q & ~in_service_q & ~irq_vec_t'(1);

  always_comb begin
    claim_clr    = '0;
    complete_clr = '0;
    for (int c = 0; c < `NUM_HARTS; c++) begin
      if (accept && claim_sel[c]) begin
        if (bus.req_write)
          complete_clr[irq_id_t'(bus.req_wdata)] = 1'b1;
        else if (claim_id[c] != '0)
          claim_clr[claim_id[c]] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_valid_q  <= 1'b0;
      pending_q    <= '0;
      in_service_q <= '0;
      meip_o       <= '0;
      for (int c = 0; c < `NUM_HARTS; c++)
        enable_q[c] <= '0;
    end else begin
      if (accept)
        rsp_valid_q <= 1'b1;
      else if (rsp_done)
        rsp_valid_q <= 1'b0;
      pending_q    <= (pending_q | gw_set) & ~claim_clr;
      in_service_q <= (in_service_q | claim_clr) & ~complete_clr;
      for (int c = 0; c < `NUM_HARTS; c++) begin
        meip_o[c] <= |(pending_q & enable_q[c]);
        if (accept && bus.req_write && enable_sel[c])
          enable_q[c] <= irq_vec_t'(bus.req_wdata) & ~irq_vec_t'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept)
      rdata_q <= rd_data;
  end

endmodule

// ==== design/clint.sv ====
`timescale 1ns/1ps
`include "io_defines.svh"

module clint (
  input  logic              clk_i,
  input  logic              reset_i,
  reg_bus_if.device         bus,
  output io_pkg::hart_vec_t msip_o,
  output io_pkg::hart_vec_t mtip_o
);
  import io_pkg::*;

  hart_vec_t msip_q;
  io_data_t  mtime_q;
  io_data_t  mtimecmp_q [`NUM_HARTS];
  io_addr_t  ofs;
  hart_vec_t msip_sel;
  hart_vec_t cmp_sel;
  io_data_t  rd_data;
  io_data_t  rdata_q;
  logic      rsp_valid_q;
  logic      accept;
  logic      rsp_done;

  assign ofs      = bus.req_addr & `CLINT_MASK;
  assign accept   = bus.req_valid & bus.req_ready;
  assign rsp_done = bus.rsp_valid & bus.rsp_ready;

  assign bus.req_ready = ~rsp_valid_q;
  assign bus.rsp_valid = rsp_valid_q;
  assign bus.rsp_rdata = rdata_q;
  assign bus.rsp_error = 1'b0;

  // unknown offsets read as zero
  always_comb begin
    rd_data  = '0;
    msip_sel = '0;
    cmp_sel  = '0;
    if (ofs == `CLINT_MTIME_OFS)
      rd_data = mtime_q;
    for (int h = 0; h < `NUM_HARTS; h++) begin
      if (ofs == `CLINT_MSIP_OFS + io_addr_t'(4 * h)) begin
        msip_sel[h] = 1'b1;
        rd_data     = io_data_t'(msip_q[h]);
      end
      if (ofs == `CLINT_MTIMECMP_OFS + io_addr_t'(8 * h)) begin
        cmp_sel[h] = 1'b1;
        rd_data    = mtimecmp_q[h];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_valid_q <= 1'b0;
      msip_q      <= '0;
      mtime_q     <= '0;
      msip_o      <= '0;
      mtip_o      <= '0;
      for (int h = 0; h < `NUM_HARTS; h++)
        mtimecmp_q[h] <= '1;
    end else begin
      if (accept)
        rsp_valid_q <= 1'b1;
      else if (rsp_done)
        rsp_valid_q <= 1'b0;
      mtime_q <= mtime_q + 1'b1;
      msip_o  <= msip_q;
      for (int h = 0; h < `NUM_HARTS; h++) begin
        mtip_o[h] <= (mtime_q >= mtimecmp_q[h]);
        if (accept && bus.req_write && msip_sel[h])
          msip_q[h] <= bus.req_wdata[0];
        if (accept && bus.req_write && cmp_sel[h])
          mtimecmp_q[h] <= bus.req_wdata;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept)
      rdata_q <= rd_data;
  end

endmodule

// ==== design/io_router.sv ====
`timescale 1ns/1ps
`include "io_defines.svh"

module io_router (
  input  logic      clk_i,
  input  logic      reset_i,
  reg_bus_if.device up_bus,
  reg_bus_if.host   clint_bus,
  reg_bus_if.host   plic_bus
);
  import io_pkg::*;

  io_target_e target;
  logic       dev_ready;
  logic       outstanding_q;
  logic       err_valid_q;
  logic       accept;
  logic       rsp_done;

  ////////////////////////////////////////////////////////////
  // address decode

  always_comb begin
    if ((up_bus.req_addr & ~`CLINT_MASK) == `CLINT_BASE)
      target = CLINT;
    else if ((up_bus.req_addr & ~`PLIC_MASK) == `PLIC_BASE)
      target = PLIC;
    else
      target = ERROR;
  end

  // request goes out to both, valid only to the selected one
  assign clint_bus.req_valid = up_bus.req_valid & ~outstanding_q & (target == CLINT);
  assign clint_bus.req_write = up_bus.req_write;
  assign clint_bus.req_addr  = up_bus.req_addr;
  assign clint_bus.req_wdata = up_bus.req_wdata;
  assign clint_bus.rsp_ready = up_bus.rsp_ready;

  assign plic_bus.req_valid = up_bus.req_valid & ~outstanding_q & (target == PLIC);
  assign plic_bus.req_write = up_bus.req_write;
  assign plic_bus.req_addr  = up_bus.req_addr;
  assign plic_bus.req_wdata = up_bus.req_wdata;
  assign plic_bus.rsp_ready = up_bus.rsp_ready;

  always_comb begin
    case (target)
      CLINT:   dev_ready = clint_bus.req_ready;
      PLIC:    dev_ready = plic_bus.req_ready;
      default: dev_ready = 1'b1;
    endcase
  end

  assign up_bus.req_ready = dev_ready & ~outstanding_q;

  assign accept   = up_bus.req_valid & up_bus.req_ready;
  assign rsp_done = up_bus.rsp_valid & up_bus.rsp_ready;

  ////////////////////////////////////////////////////////////
  // response mux, error responder last

  always_comb begin
    if (clint_bus.rsp_valid) begin
      up_bus.rsp_valid = 1'b1;
      up_bus.rsp_rdata = clint_bus.rsp_rdata;
      up_bus.rsp_error = clint_bus.rsp_error;
    end else if (plic_bus.rsp_valid) begin
      up_bus.rsp_valid = 1'b1;
      up_bus.rsp_rdata = plic_bus.rsp_rdata;
      up_bus.rsp_error = plic_bus.rsp_error;
    end else begin
      up_bus.rsp_valid = err_valid_q;
      up_bus.rsp_rdata = '0;
      up_bus.rsp_error = err_valid_q;
    end
  end

  // one request in flight at a time
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      outstanding_q <= 1'b0;
      err_valid_q   <= 1'b0;
    end else begin
      if (accept)
        outstanding_q <= 1'b1;
      else if (rsp_done)
        outstanding_q <= 1'b0;
      if (accept && target == ERROR)
        err_valid_q <= 1'b1;
      else if (rsp_done)
        err_valid_q <= 1'b0;
    end
  end

endmodule

// ==== design/reg_bus_if.sv ====
`timescale 1ns/1ps

interface reg_bus_if;
  import io_pkg::*;

  // request channel
  logic     req_valid;
  logic     req_ready;
  logic     req_write;
  io_addr_t req_addr;
  io_data_t req_wdata;

  // response channel
  logic     rsp_valid;
  logic     rsp_ready;
  io_data_t rsp_rdata;
  logic     rsp_error;

  modport host (
    output req_valid, req_write, req_addr, req_wdata, rsp_ready,
    input  req_ready, rsp_valid, rsp_rdata, rsp_error
  );

  modport device (
    input  req_valid, req_write, req_addr, req_wdata, rsp_ready,
    output req_ready, rsp_valid, rsp_rdata, rsp_error
  );

endinterface

// ==== design/io_pkg.sv ====
`include "io_defines.svh"

package io_pkg;

  // bus words
  typedef logic [`IO_ADDR_WIDTH-1:0] io_addr_t;
  typedef logic [`IO_DATA_WIDTH-1:0] io_data_t;

  // interrupt vectors
  typedef logic [`NUM_HARTS-1:0] hart_vec_t;
  typedef logic [`NUM_IRQS-1:0] irq_vec_t;

  // source number, 0 means no interrupt
  typedef logic [$clog2(`NUM_IRQS)-1:0] irq_id_t;

  // router destinations
  typedef enum logic [1:0] {
    CLINT = 2'd0,
    PLIC  = 2'd1,
    ERROR = 2'd2
  } io_target_e;

endpackage

// ==== include/io_defines.svh ====
`ifndef IO_DEFINES_SVH
`define IO_DEFINES_SVH

// bus widths
`define IO_ADDR_WIDTH 32
`define IO_DATA_WIDTH 64

// one plic context per hart
`define NUM_HARTS 2
`define NUM_IRQS 32

// address windows
`define CLINT_BASE 32'h1140_0000
`define CLINT_MASK 32'h0000_FFFF
`define PLIC_BASE 32'h1100_0000
`define PLIC_MASK 32'h003F_FFFF

// clint offsets
`define CLINT_MSIP_OFS 32'h0000_0000
`define CLINT_MTIMECMP_OFS 32'h0000_4000
`define CLINT_MTIME_OFS 32'h0000_BFF8

// plic offsets
`define PLIC_PENDING_OFS 32'h0000_1000
`define PLIC_ENABLE_OFS 32'h0000_2000
`define PLIC_CLAIM_OFS 32'h0020_0004

// source numbers of the board irq lines
`define IRQ_UART 1
`define IRQ_SD 2

`endif
